//--- src/consmax_pkg.sv
`default_nettype none

package consmax_pkg;

    localparam int idata_bit = 8;    // Input score
    localparam int odata_bit = 8;    // Output integer
    localparam int cdata_bit = 8;    // Shift config with 0..15 used

    localparam int exp_bit   = 8;
    localparam int mat_bit   = 7;
    localparam int lut_data  = exp_bit + mat_bit + 1;
    localparam int lut_addr  = 4;    // One nibble per table
    localparam int lut_depth = 16;

    localparam logic [exp_bit-1:0] exp_bias = 8'd127;

    localparam int num_head  = 2;
    localparam int num_lane  = 4;    // Lanes per head
    localparam int head_bits = num_lane * idata_bit;

    // Plain bfloat16 layout
    typedef struct packed {
        logic               sign;
        logic [exp_bit-1:0] exp;
        logic [mat_bit-1:0] mant;
    } bf16_t;

    // Write port shared by every lane table
    typedef struct packed {
        logic                wen;
        logic                sel;      // High nibble table when set
        logic [lut_addr-1:0] addr;
        bf16_t               wdata;
    } lut_wr_t;

    // Lane j sits at index j
    typedef logic [num_lane-1:0][idata_bit-1:0] head_data_t;

endpackage

`default_nettype wire

//--- src/consmax_lut.sv
`timescale 1ns/1ps
`default_nettype none

module consmax_lut (
    input  wire logic                             clk,
    input  wire logic [consmax_pkg::lut_addr-1:0] addr,
    input  wire logic                             wen,
    input  wire consmax_pkg::bf16_t               wdata,
    input  wire logic                             ren,
    output consmax_pkg::bf16_t                    rdata
);

    logic [consmax_pkg::lut_data-1:0] mem [consmax_pkg::lut_depth];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
    end

    // Read data holds between lookups
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- src/bf16_mul.sv
`timescale 1ns/1ps
`default_nettype none

module bf16_mul (
    input  wire consmax_pkg::bf16_t a,
    input  wire consmax_pkg::bf16_t b,
    output consmax_pkg::bf16_t      result
);

    logic                                   sign;
    logic                                   zero_in;
    logic [2*consmax_pkg::mat_bit+1:0]      prod;
    logic                                   norm;
    logic [consmax_pkg::mat_bit-1:0]        mant_n;
    logic signed [consmax_pkg::exp_bit+1:0] exp_sum;

    assign sign    = a.sign ^ b.sign;
    assign zero_in = (a.exp == '0) || (b.exp == '0);   // No denormals

    // Mantissas with hidden ones give a product in [1, 4)
    assign prod = {1'b1, a.mant} * {1'b1, b.mant};
    assign norm = prod[2*consmax_pkg::mat_bit+1];

    // Truncated without rounding
    assign mant_n = norm ? prod[2*consmax_pkg::mat_bit -: consmax_pkg::mat_bit]
                         : prod[2*consmax_pkg::mat_bit-1 -: consmax_pkg::mat_bit];

    // Two guard bits catch both underflow and overflow
    assign exp_sum = $signed({2'b00, a.exp}
                           + {2'b00, b.exp}
                           + {{(consmax_pkg::exp_bit+1){1'b0}}, norm}
                           - {2'b00, consmax_pkg::exp_bias});

    always_comb begin
        result.sign = sign;
        if (zero_in || exp_sum <= 10'sd0) begin
            result.exp  = '0;                // Signed zero
            result.mant = '0;
        end else if (exp_sum >= 10'sd255) begin
            // Clamp to the largest finite value
            result.exp  = {{(consmax_pkg::exp_bit-1){1'b1}}, 1'b0};
            result.mant = '1;
        end else begin
            result.exp  = exp_sum[consmax_pkg::exp_bit-1:0];
            result.mant = mant_n;
        end
    end

endmodule

`default_nettype wire

//--- src/fp_to_int.sv
`timescale 1ns/1ps
`default_nettype none

module fp_to_int (
    input  wire logic [consmax_pkg::cdata_bit-1:0]   shift,
    input  wire consmax_pkg::bf16_t                  fp,
    output logic signed [consmax_pkg::odata_bit-1:0] value
);

    logic [consmax_pkg::exp_bit:0]     up;        // Integer bits above the point
    logic [consmax_pkg::exp_bit:0]     down;      // Exponent distance below 1.0
    logic                              half_only; // Value in [0.5, 1)
    logic                              ovf;
    logic                              unf;
    logic [2:0]                        rsh;
    logic [consmax_pkg::mat_bit:0]     mag;
    logic [consmax_pkg::mat_bit+1:0]   twice;     // Value times 2 with the guard at the lsb
    logic [consmax_pkg::mat_bit+1:0]   rnd;
    logic [consmax_pkg::odata_bit-2:0] int_mag;

    assign mag = {1'b1, fp.mant};

    always_comb begin
        up        = '0;
        down      = {1'b0, consmax_pkg::exp_bias} - {1'b0, fp.exp};
        half_only = 1'b0;
        ovf       = 1'b0;
        unf       = 1'b0;
        rsh       = '0;
        if (fp.exp == '0) begin
            unf = 1'b1;
        end else if (fp.exp >= consmax_pkg::exp_bias) begin      // At or above 1.0
            up = {1'b0, fp.exp} - {1'b0, consmax_pkg::exp_bias} + {1'b0, shift};
        end else if ({1'b0, shift} >= down) begin  // Shift lifts it back over 1.0
            up = {1'b0, shift} - down;
        end else if (down - {1'b0, shift} == 9'd1) begin
            half_only = 1'b1;
        end else begin
            unf = 1'b1;                            // Below one half
        end

        if (!unf && !half_only) begin
            if (up >= 9'd7) begin
                ovf = 1'b1;                        // At least 128
            end else begin
                rsh = 3'd6 - up[2:0];
            end
        end else if (half_only) begin
            rsh = 3'd7;
        end
    end

    assign twice = {1'b0, mag} >> rsh;
    assign rnd   = (twice + 9'd1) >> 1;            // Half up

    always_comb begin
        if (unf) begin
            int_mag = '0;
        end else if (ovf || rnd[consmax_pkg::mat_bit+1 -: 2] != 2'b00) begin
            int_mag = '1;
        end else begin
            int_mag = rnd[consmax_pkg::odata_bit-2:0];
        end
    end

    assign value = fp.sign ? (~{1'b0, int_mag} + 8'd1) : {1'b0, int_mag};

endmodule

`default_nettype wire

//--- src/consmax_lane.sv
`timescale 1ns/1ps
`default_nettype none

module consmax_lane (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic [consmax_pkg::cdata_bit-1:0] cfg_shift,
    input  wire consmax_pkg::lut_wr_t              lut_wr,
    input  wire logic [consmax_pkg::idata_bit-1:0] idata,
    input  wire logic                              idata_valid,
    output logic      [consmax_pkg::odata_bit-1:0] odata,
    output logic                                   odata_valid
);

    logic [consmax_pkg::idata_bit-1:0]        score_q;
    logic                                     valid_q;
    logic                                     lut_ren;
    logic                                     rd_valid_q;
    logic [consmax_pkg::lut_addr-1:0]         nib      [2];
    logic [consmax_pkg::lut_addr-1:0]         tab_addr [2];
    logic                                     tab_wen  [2];
    consmax_pkg::bf16_t                       tab_rdata [2];
    consmax_pkg::bf16_t                       product;
    logic signed [consmax_pkg::odata_bit-1:0] conv;

    // Stage 1
    always_ff @(posedge clk) begin
        if (idata_valid) begin
            score_q <= idata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= idata_valid;
        end
    end

    assign nib[0]  = score_q[consmax_pkg::lut_addr-1:0];
    assign nib[1]  = score_q[consmax_pkg::idata_bit-1 -: consmax_pkg::lut_addr];
    assign lut_ren = valid_q && !lut_wr.wen;       // Any write kills the lookup

    // Stage 2 where table 0 serves the low nibble
    for (genvar t = 0; t < 2; t++) begin : g_tab
        assign tab_wen[t]  = lut_wr.wen && (lut_wr.sel == 1'(t));
        assign tab_addr[t] = tab_wen[t] ? lut_wr.addr : nib[t];

        consmax_lut lut_i (
            .clk   (clk),
            .addr  (tab_addr[t]),
            .wen   (tab_wen[t]),
            .wdata (lut_wr.wdata),
            .ren   (lut_ren),
            .rdata (tab_rdata[t])
        );
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= lut_ren;
        end
    end

    // exp(lo) * exp(hi) gives exp(score)
    bf16_mul mul_i (
        .a      (tab_rdata[0]),
        .b      (tab_rdata[1]),
        .result (product)
    );

    fp_to_int conv_i (
        .shift (cfg_shift),
        .fp    (product),
        .value (conv)
    );

    // Stage 3
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            odata       <= '0;
            odata_valid <= 1'b0;
        end else begin
            odata_valid <= rd_valid_q;
            if (rd_valid_q) begin
                odata <= conv;      // Held when the read was dropped
            end
        end
    end

endmodule

`default_nettype wire

//--- src/consmax_bus.sv
`timescale 1ns/1ps
`default_nettype none

module consmax_bus (
    input  wire logic                                                       clk,
    input  wire logic                                                       rstn,
    input  wire logic [consmax_pkg::cdata_bit-1:0]                          cfg_shift,
    input  wire consmax_pkg::lut_wr_t                                       lut_wr,
    input  wire consmax_pkg::head_data_t [consmax_pkg::num_head-1:0]        idata,
    input  wire logic [consmax_pkg::num_head-1:0]                           idata_valid,
    output wire consmax_pkg::head_data_t [consmax_pkg::num_head-1:0]        odata,
    output wire logic [consmax_pkg::num_head*consmax_pkg::num_lane-1:0]     odata_valid
);

    // One strobe per head and one valid back per lane
    for (genvar h = 0; h < consmax_pkg::num_head; h++) begin : g_head
        for (genvar j = 0; j < consmax_pkg::num_lane; j++) begin : g_lane
            consmax_lane lane_i (
                .clk         (clk),
                .rstn        (rstn),
                .cfg_shift   (cfg_shift),     // Global
                .lut_wr      (lut_wr),        // Same tables loaded everywhere
                .idata       (idata[h][j]),
                .idata_valid (idata_valid[h]),
                .odata       (odata[h][j]),
                .odata_valid (odata_valid[h*consmax_pkg::num_lane+j])
            );
        end
    end

endmodule

`default_nettype wire

//--- include/consmax_ref.svh
`ifndef CONSMAX_REF_SVH
`define CONSMAX_REF_SVH

// Bit-exact bfloat16 product, truncating like the hardware
function automatic consmax_pkg::bf16_t ref_mul(input consmax_pkg::bf16_t a,
                                               input consmax_pkg::bf16_t b);
    consmax_pkg::bf16_t r;
    int unsigned        prod;
    int unsigned        tmp;
    int                 norm;
    int                 e;
    r.sign = a.sign ^ b.sign;
    r.exp  = '0;
    r.mant = '0;
    if (a.exp == 0 || b.exp == 0) begin
        return r;
    end
    prod = int'({1'b1, a.mant}) * int'({1'b1, b.mant});
    norm = (prod >= (1 << (2 * consmax_pkg::mat_bit + 1))) ? 1 : 0;
    e    = int'(a.exp) + int'(b.exp) - int'(consmax_pkg::exp_bias) + norm;
    if (e <= 0) begin
        return r;
    end
    if (e >= 255) begin
        r.exp  = 8'hfe;
        r.mant = '1;
        return r;
    end
    tmp    = prod >> (consmax_pkg::mat_bit + norm);
    r.exp  = e[consmax_pkg::exp_bit-1:0];
    r.mant = tmp[consmax_pkg::mat_bit-1:0];
    return r;
endfunction

// Scales the value in real arithmetic and rounds half up
function automatic logic [consmax_pkg::odata_bit-1:0] ref_conv(
    input consmax_pkg::bf16_t                  fp,
    input logic [consmax_pkg::cdata_bit-1:0]   shift);
    real mag;
    int  k;
    int  r;
    if (fp.exp == 0) begin
        return '0;
    end
    k   = int'(fp.exp) - int'(consmax_pkg::exp_bias) + int'(shift);
    mag = real'(int'({1'b1, fp.mant})) * (2.0 ** (k - consmax_pkg::mat_bit));
    if (mag >= 127.0) begin
        r = 127;
    end else begin
        r = int'($floor(mag + 0.5));
    end
    if (fp.sign) begin
        r = -r;
    end
    return r[consmax_pkg::odata_bit-1:0];
endfunction

// Full lane result from the two table entries
function automatic logic [consmax_pkg::odata_bit-1:0] ref_lane(
    input consmax_pkg::bf16_t                  lo,
    input consmax_pkg::bf16_t                  hi,
    input logic [consmax_pkg::cdata_bit-1:0]   shift);
    return ref_conv(ref_mul(lo, hi), shift);
endfunction

`endif

//--- bench/consmax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module consmax_tb;

    localparam int          period    = 100;
    localparam logic [31:0] seed      = 32'h90f1f668;
    localparam int          lanes     = consmax_pkg::num_head * consmax_pkg::num_lane;
    localparam int          run_limit = 6000;     // Cycles for the whole run
    localparam logic [7:0]  shifts [3] = '{8'd0, 8'd7, 8'd15};

    typedef consmax_pkg::head_data_t [consmax_pkg::num_head-1:0] bus_data_t;

    logic                              clk;
    logic                              rstn;
    logic [consmax_pkg::cdata_bit-1:0] cfg_shift;
    consmax_pkg::lut_wr_t              lut_wr;
    bus_data_t                         idata;
    logic [consmax_pkg::num_head-1:0]  idata_valid;
    bus_data_t                         odata;
    logic [lanes-1:0]                  odata_valid;

    logic [31:0]        rng       = seed;
    int                 errors    = 0;
    int                 cyc       = 0;        // Rising edges so far
    logic               mon_en    = 1'b0;
    logic               done      = 1'b0;
    logic               timed_out = 1'b0;
    logic [7:0]         shift_now = 8'd4;
    consmax_pkg::bf16_t shadow [2][consmax_pkg::lut_depth];
    logic               pend_valid [lanes];   // Driven last cycle and not yet read
    logic [7:0]         pend_score [lanes];
    logic [7:0]         held [lanes];
    logic [39:0]        exp_q [lanes][$];     // Due cycle over expected value

    `include "consmax_ref.svh"

    consmax_bus dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_shift   (cfg_shift),
        .lut_wr      (lut_wr),
        .idata       (idata),
        .idata_valid (idata_valid),
        .odata       (odata),
        .odata_valid (odata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_eq(input string what, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_lane(input int l);
        logic [7:0]  got;
        logic [39:0] item;
        int          due;
        got = odata[l / consmax_pkg::num_lane][l % consmax_pkg::num_lane];
        due = 32'h7fff_ffff;
        if (exp_q[l].size() > 0) begin
            item = exp_q[l][0];
            due  = int'(item[39:8]);
        end
        if (odata_valid[l] && exp_q[l].size() == 0) begin
            errors++;
            $display("Lane %0d raised odata_valid at cycle %0d with no input behind it", l, cyc);
        end else if (odata_valid[l] || due <= cyc) begin
            void'(exp_q[l].pop_front());
            check_eq($sformatf("lane %0d result cycle", l), odata_valid[l] ? cyc : -1, due);
            if (odata_valid[l]) begin
                check_eq($sformatf("lane %0d odata", l), int'(got), int'(item[7:0]));
                held[l] = item[7:0];
            end
        end else begin
            // No pulse, so the last result must still be there
            check_eq($sformatf("lane %0d held odata", l), int'(got), int'(held[l]));
        end
    endtask

    always @(negedge clk) begin
        if (mon_en) begin
            for (int l = 0; l < lanes; l++) begin
                check_lane(l);
            end
        end
    end

    // One clock of stimulus; last cycle's items read at the edge that samples wr
    task automatic drive_cycle(input consmax_pkg::lut_wr_t wr, input bus_data_t d,
                               input logic [consmax_pkg::num_head-1:0] v);
        consmax_pkg::bf16_t lo;
        consmax_pkg::bf16_t hi;
        @(posedge clk);
        for (int l = 0; l < lanes; l++) begin
            if (pend_valid[l] && !wr.wen) begin
                lo = shadow[0][pend_score[l][3:0]];
                hi = shadow[1][pend_score[l][7:4]];
                exp_q[l].push_back({32'(cyc + 3), ref_lane(lo, hi, shift_now)});
            end
            pend_valid[l] = v[l / consmax_pkg::num_lane];
            pend_score[l] = d[l / consmax_pkg::num_lane][l % consmax_pkg::num_lane];
        end
        if (wr.wen) begin
            shadow[wr.sel][wr.addr] = wr.wdata;
        end
        lut_wr      <= wr;
        idata       <= d;
        idata_valid <= v;
        cfg_shift   <= shift_now;
    endtask

    task automatic drain();
        int   waited;
        logic busy;
        waited = 0;
        busy   = 1'b1;
        while (busy && !timed_out) begin
            drive_cycle('0, '0, '0);
            busy = 1'b0;
            for (int l = 0; l < lanes; l++) begin
                if (pend_valid[l] || exp_q[l].size() > 0) begin
                    busy = 1'b1;
                end
            end
            waited++;
            if (busy && waited > 10) begin
                timed_out = 1'b1;
                $display("Timeout: lane results still outstanding after %0d idle cycles", waited);
            end
        end
    endtask

    // Positive normals near 1.0 or a mix of zero, huge, tiny and signed entries
    function automatic consmax_pkg::bf16_t table_entry(input logic [3:0] addr, input bit special);
        consmax_pkg::bf16_t v;
        logic [31:0]        r;
        r      = next_rand();
        v.sign = 1'b0;
        v.mant = r[6:0];
        v.exp  = 8'd122 + 8'(r[10:8]);
        if (special) begin
            case (addr[1:0])
                2'd0:    v.exp  = 8'd0;
                2'd1:    v.exp  = 8'd190 + 8'(addr[3:2]) * 8'd4;  // Products can clamp
                2'd2:    v.exp  = 8'd40 + 8'(addr[3:2]);          // Products can flush
                default: v.sign = addr[2];                        // Negative only on 7 and 15
            endcase
        end
        return v;
    endfunction

    task automatic load_tables(input bit special);
        consmax_pkg::lut_wr_t wr;
        for (int i = 0; i < 2 * consmax_pkg::lut_depth; i++) begin
            wr.wen   = 1'b1;
            wr.sel   = i[4];
            wr.addr  = i[3:0];
            wr.wdata = table_entry(i[3:0], special);
            drive_cycle(wr, '0, '0);
        end
    endtask

    // Sweep mode gives every lane all 256 scores in a per-lane order
    task automatic send_scores(input int n, input bit rnd_mode);
        bus_data_t                        d;
        logic [consmax_pkg::num_head-1:0] v;
        logic [31:0]                      r;
        logic [7:0]                       score;
        for (int i = 0; i < n; i++) begin
            for (int l = 0; l < lanes; l++) begin
                r     = next_rand();
                score = rnd_mode ? r[7:0] : 8'(i + 37 * l);
                d[l / consmax_pkg::num_lane][l % consmax_pkg::num_lane] = score;
            end
            r = next_rand();
            v = rnd_mode ? r[1:0] : '1;
            drive_cycle('0, d, v);
        end
        drain();
    endtask

    task automatic write_priority(input int n);
        consmax_pkg::lut_wr_t wr;
        bus_data_t            d;
        logic [31:0]          r;
        for (int i = 0; i < n; i++) begin
            r        = next_rand();
            d        = {(2 * consmax_pkg::num_lane){r[7:0]}};
            wr.wen   = 1'b1;
            wr.sel   = r[8];
            wr.addr  = r[8] ? r[7:4] : r[3:0];
            wr.wdata = table_entry(wr.addr, 1'b0);
            drive_cycle('0, d, 2'b11);      // Dropped at its read edge
            drive_cycle(wr, '0, '0);
            drive_cycle('0, d, 2'b11);      // Reads the new entry
            drain();
        end
    endtask

    initial begin
        rstn        = 1'b1;
        cfg_shift   = shift_now;
        lut_wr      = '0;
        idata       = '0;
        idata_valid = '0;
        for (int l = 0; l < lanes; l++) begin
            pend_valid[l] = 1'b0;
            held[l]       = '0;             // Reset value of odata
        end
        @(posedge clk);
        rstn   <= 1'b0;
        mon_en <= 1'b1;                     // Zero outputs checked from here on
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        load_tables(1'b0);
        send_scores(256, 1'b0);
        send_scores(400, 1'b1);
        load_tables(1'b1);
        for (int i = 0; i < 3; i++) begin
            shift_now = shifts[i];
            send_scores(256, 1'b0);
        end
        shift_now = 8'd4;
        load_tables(1'b0);
        write_priority(8);
        repeat (4) drive_cycle('0, '0, '0);
        done = 1'b1;
    end

    initial begin
        int waited;
        waited = 0;
        while (!done && !timed_out && waited < run_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!done && !timed_out) begin
            $display("Timeout: stimulus did not finish within %0d cycles", run_limit);
        end
        $display("Checks finished with %0d errors", errors);
        if (done && !timed_out && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/consmax_pkg.sv
src/consmax_lut.sv
src/bf16_mul.sv
src/fp_to_int.sv
src/consmax_lane.sv
src/consmax_bus.sv
bench/consmax_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = consmax_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
